// ==== hw/miner_ctrl_params.svh ====
/*
 * Miner controller constants
 * Register map, lane count and field widths
 */
`ifndef MINER_CTRL_PARAMS_SVH
`define MINER_CTRL_PARAMS_SVH

// Field widths
`define ADDR_WIDTH      32
`define WORD_WIDTH      32
`define NONCE_WIDTH     32
`define TICK_WIDTH      8
`define COUNT_WIDTH     16

// Work shape
`define MINER_LANES     3
`define BLOCK_WORDS     20

// Host register map, byte offsets
`define REG_BLOCK_BASE  32'h0000_0504
`define REG_BLOCK_LAST  32'h0000_0550
`define REG_RESULT      32'h0000_0554
`define REG_CNT_CTRL    32'h0000_0560
`define REG_CNT_TICK    32'h0000_0564
`define REG_CNT_LOAD    32'h0000_0568
`define REG_CNT_WMARK   32'h0000_056C
`define REG_CNT_STATUS  32'h0000_0570

// Counter control bits in REG_CNT_CTRL
`define CTRL_ENABLE_BIT  0
`define CTRL_LOAD_BIT    1
`define CTRL_CLEAR_BIT   2
`define CTRL_ONESHOT_BIT 3

`define UNMAPPED_DATA   32'hFFFF_FFFF

`endif

// ==== hw/miner_reg_pkg.sv ====
/*
 * Host register bus types
 * Address, data, strobe and response of the AXI-Lite slave port
 */
`include "miner_ctrl_params.svh"
`default_nettype none

package miner_reg_pkg;

  // Byte address as seen on awaddr/araddr
  typedef logic [`ADDR_WIDTH-1:0] reg_addr_t;

  typedef logic [`WORD_WIDTH-1:0] reg_data_t;

  // One strobe bit per byte lane
  typedef logic [`WORD_WIDTH/8-1:0] reg_strb_t;

  // Only OKAY is ever returned
  typedef enum logic [1:0] {
    RESP_OKAY = 2'b00
  } axi_resp_t;

endpackage

`default_nettype wire

// ==== hw/miner_work_pkg.sv ====
/*
 * Mining work and result types
 * Block header, nonce and debug counter fields
 */
`include "miner_ctrl_params.svh"
`default_nettype none

package miner_work_pkg;

  // Word 0 of the header sits in the top 32 bits
  typedef logic [`BLOCK_WORDS*`WORD_WIDTH-1:0] block_t;

  typedef logic [`NONCE_WIDTH-1:0] nonce_t;

  // Debug counter fields
  typedef logic [`TICK_WIDTH-1:0]  tick_t;
  typedef logic [`COUNT_WIDTH-1:0] count_t;

endpackage

`default_nettype wire

// ==== hw/ocl_axil_slave.sv ====
/*
 * Single-beat AXI-Lite slave
 * Turns host write beats into register write strobes and reads into
 * read requests with registered read data
 */
`timescale 1ns/1ns
`default_nettype none

module ocl_axil_slave (
  input  logic                      clk_main_a0,
  input  logic                      rst_main_n_sync,
  // Write address
  input  logic                      awvalid,
  input  miner_reg_pkg::reg_addr_t  awaddr,
  output logic                      awready,
  // Write data
  input  logic                      wvalid,
  input  miner_reg_pkg::reg_data_t  wdata,
  input  miner_reg_pkg::reg_strb_t  wstrb,
  output logic                      wready,
  // Write response
  output logic                      bvalid,
  output miner_reg_pkg::axi_resp_t  bresp,
  input  logic                      bready,
  // Read address
  input  logic                      arvalid,
  input  miner_reg_pkg::reg_addr_t  araddr,
  output logic                      arready,
  // Read data
  output logic                      rvalid,
  output miner_reg_pkg::reg_data_t  rdata,
  output miner_reg_pkg::axi_resp_t  rresp,
  input  logic                      rready,
  // Register side
  output logic                      wr_en,
  output miner_reg_pkg::reg_addr_t  wr_addr,
  output miner_reg_pkg::reg_data_t  wr_data,
  output logic                      rd_en,
  output miner_reg_pkg::reg_addr_t  rd_addr,
  input  miner_reg_pkg::reg_data_t  rd_data
);

  logic                     wr_active;
  logic                     rd_pend;
  miner_reg_pkg::reg_addr_t aw_addr_q;
  miner_reg_pkg::reg_addr_t ar_addr_q;

  // --------------------------------------------------------------------------
  // Write path
  // --------------------------------------------------------------------------
  assign awready = ~wr_active;
  // One W beat per write, closed off once the response is up
  assign wready  = wr_active & ~bvalid & wvalid;
  assign bresp   = miner_reg_pkg::RESP_OKAY;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      wr_active <= 1'b0;
      bvalid    <= 1'b0;
    end else begin
      if (awvalid && awready) begin
        wr_active <= 1'b1;
      end else if (bvalid && bready) begin
        wr_active <= 1'b0;
      end
      if (wready) begin
        bvalid <= 1'b1;
      end else if (bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_main_a0) begin
    if (awvalid && awready) begin
      aw_addr_q <= awaddr;
    end
  end

  // A beat with no strobes set writes nothing
  assign wr_en   = wready & (|wstrb);
  assign wr_addr = aw_addr_q;
  assign wr_data = wdata;

  // --------------------------------------------------------------------------
  // Read path
  // --------------------------------------------------------------------------
  assign arready = ~rd_pend & ~rvalid;
  assign rresp   = miner_reg_pkg::RESP_OKAY;
  assign rd_en   = rd_pend;
  assign rd_addr = ar_addr_q;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      rd_pend <= 1'b0;
      rvalid  <= 1'b0;
    end else begin
      rd_pend <= arvalid & arready;
      if (rd_pend) begin
        rvalid <= 1'b1;
      end else if (rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_main_a0) begin
    if (arvalid && arready) begin
      ar_addr_q <= araddr;
    end
    if (rd_pend) begin
      rdata <= rd_data;
    end
  end

  // A write response only stands inside an open write
  a_bvalid_in_write : assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    bvalid |-> wr_active);

  // Read response held until the host takes it
  a_rdata_hold : assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    rvalid && !rready |=> rvalid && $stable(rdata));

endmodule

`default_nettype wire

// ==== hw/miner_csr.sv ====
/*
 * Miner control and status registers
 * Block header words, new-block pulse, counter controls and read decode
 */
`timescale 1ns/1ns
`include "miner_ctrl_params.svh"
`default_nettype none

module miner_csr (
  input  logic                      clk_main_a0,
  input  logic                      rst_main_n_sync,
  input  logic                      wr_en,
  input  miner_reg_pkg::reg_addr_t  wr_addr,
  input  miner_reg_pkg::reg_data_t  wr_data,
  input  logic                      rd_en,
  input  miner_reg_pkg::reg_addr_t  rd_addr,
  input  miner_work_pkg::nonce_t    result,
  input  miner_work_pkg::count_t    cnt,
  input  miner_work_pkg::tick_t     tick_cnt,
  input  logic                      cnt_ge_wmark,
  input  logic                      tick,
  output miner_reg_pkg::reg_data_t  rd_data,
  output miner_work_pkg::block_t    block,
  output logic                      new_block,
  output logic                      cnt_enable,
  output logic                      cnt_load,
  output logic                      cnt_clear,
  output logic                      cnt_oneshot,
  output miner_work_pkg::tick_t     tick_value,
  output miner_work_pkg::count_t    load_value,
  output miner_work_pkg::count_t    watermark
);

  // --------------------------------------------------------------------------
  // Write decode
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      block       <= '0;
      new_block   <= 1'b0;
      cnt_enable  <= 1'b0;
      cnt_load    <= 1'b0;
      cnt_clear   <= 1'b0;
      cnt_oneshot <= 1'b0;
      tick_value  <= '0;
      load_value  <= '0;
      watermark   <= '0;
    end else begin
      // Last header word kicks off the miners
      new_block <= wr_en && (wr_addr == `REG_BLOCK_LAST);
      if (wr_en) begin
        for (int i = 0; i < `BLOCK_WORDS; i++) begin
          if (wr_addr == miner_reg_pkg::reg_addr_t'(`REG_BLOCK_BASE + 4 * i)) begin
            block[(`BLOCK_WORDS-1-i)*`WORD_WIDTH +: `WORD_WIDTH] <= wr_data;
          end
        end
        case (wr_addr)
          `REG_CNT_CTRL: begin
            cnt_enable  <= wr_data[`CTRL_ENABLE_BIT];
            cnt_load    <= wr_data[`CTRL_LOAD_BIT];
            cnt_clear   <= wr_data[`CTRL_CLEAR_BIT];
            cnt_oneshot <= wr_data[`CTRL_ONESHOT_BIT];
          end
          `REG_CNT_TICK:  tick_value <= wr_data[`TICK_WIDTH-1:0];
          `REG_CNT_LOAD:  load_value <= wr_data[`COUNT_WIDTH-1:0];
          `REG_CNT_WMARK: watermark  <= wr_data[`COUNT_WIDTH-1:0];
          default: ;
        endcase
      end
    end
  end

  // --------------------------------------------------------------------------
  // Read decode, answered in the request cycle
  // --------------------------------------------------------------------------
  always_comb begin
    rd_data = '0;
    if (rd_en) begin
      case (rd_addr)
        `REG_RESULT:     rd_data = result;
        // Flags above tick count above count
        `REG_CNT_STATUS: rd_data = {6'd0, tick, cnt_ge_wmark, tick_cnt, cnt};
        default:         rd_data = `UNMAPPED_DATA;
      endcase
    end
  end

  a_new_block_single : assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    new_block |=> !new_block);

endmodule

`default_nettype wire

// ==== hw/nonce_result_sel.sv ====
/*
 * Nonce result capture
 * Holds the nonce of the lowest-numbered lane that reports a find
 */
`timescale 1ns/1ns
`include "miner_ctrl_params.svh"
`default_nettype none

module nonce_result_sel (
  input  logic                                        clk_main_a0,
  input  logic                                        rst_main_n_sync,
  input  logic [`MINER_LANES-1:0]                     nonce_found,
  input  miner_work_pkg::nonce_t [`MINER_LANES-1:0]   nonce,
  output miner_work_pkg::nonce_t                      result
);

  miner_work_pkg::nonce_t sel_nonce;

  // Walk down so lane 0 wins
  always_comb begin
    sel_nonce = result;
    for (int i = `MINER_LANES - 1; i >= 0; i--) begin
      if (nonce_found[i]) begin
        sel_nonce = nonce[i];
      end
    end
  end

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      result <= '0;
    end else if (|nonce_found) begin
      result <= sel_nonce;
    end
  end

  // Lane 0 outranks every other lane
  a_lane0_wins : assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    nonce_found[0] |=> result == $past(nonce[0]));

endmodule

`default_nettype wire

// ==== hw/tick_counter.sv ====
/*
 * Debug tick counter
 * Prescaled event count with clear, load, one-shot stop and watermark flag
 */
`timescale 1ns/1ns
`default_nettype none

module tick_counter (
  input  logic                    clk_main_a0,
  input  logic                    rst_main_n_sync,
  input  logic                    cnt_enable,
  input  logic                    cnt_load,
  input  logic                    cnt_clear,
  input  logic                    cnt_oneshot,
  input  miner_work_pkg::tick_t   tick_value,
  input  miner_work_pkg::count_t  load_value,
  input  miner_work_pkg::count_t  watermark,
  output miner_work_pkg::count_t  cnt,
  output miner_work_pkg::tick_t   tick_cnt,
  output logic                    cnt_ge_wmark,
  output logic                    tick
);

  miner_work_pkg::tick_t  tick_cnt_nxt;
  miner_work_pkg::count_t cnt_nxt;
  logic                   tick_wrap;

  // Wrap also covers a tick value lowered below the running count
  assign tick_wrap = tick_cnt >= tick_value;

  always_comb begin
    tick_cnt_nxt = tick_cnt;
    cnt_nxt      = cnt;
    if (cnt_clear) begin
      tick_cnt_nxt = '0;
      cnt_nxt      = '0;
    end else if (cnt_load) begin
      cnt_nxt = load_value;
    end else if (cnt_enable) begin
      if (tick_wrap) begin
        tick_cnt_nxt = '0;
        // One-shot parks at all ones
        if (!(cnt_oneshot && (cnt == '1))) begin
          cnt_nxt = cnt + 1'b1;
        end
      end else begin
        tick_cnt_nxt = tick_cnt + 1'b1;
      end
    end
  end

  // Flags follow the new counts so status reads are consistent
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      tick_cnt     <= '0;
      cnt          <= '0;
      tick         <= 1'b0;
      cnt_ge_wmark <= 1'b0;
    end else begin
      tick_cnt     <= tick_cnt_nxt;
      cnt          <= cnt_nxt;
      tick         <= tick_cnt_nxt >= tick_value;
      cnt_ge_wmark <= cnt_nxt >= watermark;
    end
  end

endmodule

`default_nettype wire

// ==== hw/miner_ctrl.sv ====
/*
 * Miner controller top
 * AXI-Lite register access, block header export, nonce capture, debug counter
 */
`timescale 1ns/1ns
`include "miner_ctrl_params.svh"
`default_nettype none

module miner_ctrl (
  input  logic                                        clk_main_a0,
  input  logic                                        rst_main_n_sync,
  input  logic                                        awvalid,
  input  miner_reg_pkg::reg_addr_t                    awaddr,
  output logic                                        awready,
  input  logic                                        wvalid,
  input  miner_reg_pkg::reg_data_t                    wdata,
  input  miner_reg_pkg::reg_strb_t                    wstrb,
  output logic                                        wready,
  output logic                                        bvalid,
  output miner_reg_pkg::axi_resp_t                    bresp,
  input  logic                                        bready,
  input  logic                                        arvalid,
  input  miner_reg_pkg::reg_addr_t                    araddr,
  output logic                                        arready,
  output logic                                        rvalid,
  output miner_reg_pkg::reg_data_t                    rdata,
  output miner_reg_pkg::axi_resp_t                    rresp,
  input  logic                                        rready,
  input  logic [`MINER_LANES-1:0]                     nonce_found,
  input  miner_work_pkg::nonce_t [`MINER_LANES-1:0]   nonce,
  output miner_work_pkg::block_t                      block,
  output logic                                        new_block
);

  // Register side of the slave
  logic                     wr_en;
  miner_reg_pkg::reg_addr_t wr_addr;
  miner_reg_pkg::reg_data_t wr_data;
  logic                     rd_en;
  miner_reg_pkg::reg_addr_t rd_addr;
  miner_reg_pkg::reg_data_t rd_data;

  miner_work_pkg::nonce_t   result;

  // Counter controls and status
  logic                     cnt_enable;
  logic                     cnt_load;
  logic                     cnt_clear;
  logic                     cnt_oneshot;
  miner_work_pkg::tick_t    tick_value;
  miner_work_pkg::count_t   load_value;
  miner_work_pkg::count_t   watermark;
  miner_work_pkg::count_t   cnt;
  miner_work_pkg::tick_t    tick_cnt;
  logic                     cnt_ge_wmark;
  logic                     tick;

  ocl_axil_slave i_ocl_axil_slave (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .awvalid         (awvalid),
    .awaddr          (awaddr),
    .awready         (awready),
    .wvalid          (wvalid),
    .wdata           (wdata),
    .wstrb           (wstrb),
    .wready          (wready),
    .bvalid          (bvalid),
    .bresp           (bresp),
    .bready          (bready),
    .arvalid         (arvalid),
    .araddr          (araddr),
    .arready         (arready),
    .rvalid          (rvalid),
    .rdata           (rdata),
    .rresp           (rresp),
    .rready          (rready),
    .wr_en           (wr_en),
    .wr_addr         (wr_addr),
    .wr_data         (wr_data),
    .rd_en           (rd_en),
    .rd_addr         (rd_addr),
    .rd_data         (rd_data)
  );

  miner_csr i_miner_csr (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .wr_en           (wr_en),
    .wr_addr         (wr_addr),
    .wr_data         (wr_data),
    .rd_en           (rd_en),
    .rd_addr         (rd_addr),
    .result          (result),
    .cnt             (cnt),
    .tick_cnt        (tick_cnt),
    .cnt_ge_wmark    (cnt_ge_wmark),
    .tick            (tick),
    .rd_data         (rd_data),
    .block           (block),
    .new_block       (new_block),
    .cnt_enable      (cnt_enable),
    .cnt_load        (cnt_load),
    .cnt_clear       (cnt_clear),
    .cnt_oneshot     (cnt_oneshot),
    .tick_value      (tick_value),
    .load_value      (load_value),
    .watermark       (watermark)
  );

  nonce_result_sel i_nonce_result_sel (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .nonce_found     (nonce_found),
    .nonce           (nonce),
    .result          (result)
  );

  tick_counter i_tick_counter (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .cnt_enable      (cnt_enable),
    .cnt_load        (cnt_load),
    .cnt_clear       (cnt_clear),
    .cnt_oneshot     (cnt_oneshot),
    .tick_value      (tick_value),
    .load_value      (load_value),
    .watermark       (watermark),
    .cnt             (cnt),
    .tick_cnt        (tick_cnt),
    .cnt_ge_wmark    (cnt_ge_wmark),
    .tick            (tick)
  );

endmodule

`default_nettype wire

// ==== tb/miner_ctrl_tb.sv ====
/*
 * Miner controller testbench
 * Drives the AXI-Lite port and miner lanes, checks read data, block header,
 * new-block pulse and debug counter against a register model
 */
`timescale 1ns/1ns
`include "miner_ctrl_params.svh"
`default_nettype none

module miner_ctrl_tb;

  // Roughly 2000 cycles of traffic, so this leaves a wide margin
  localparam int TIMEOUT_CYCLES = 20000;

  logic                                      clk_main_a0 = 1'b0;
  logic                                      rst_main_n_sync;
  logic                                      awvalid;
  miner_reg_pkg::reg_addr_t                  awaddr;
  logic                                      awready;
  logic                                      wvalid;
  miner_reg_pkg::reg_data_t                  wdata;
  miner_reg_pkg::reg_strb_t                  wstrb;
  logic                                      wready;
  logic                                      bvalid;
  miner_reg_pkg::axi_resp_t                  bresp;
  logic                                      bready;
  logic                                      arvalid;
  miner_reg_pkg::reg_addr_t                  araddr;
  logic                                      arready;
  logic                                      rvalid;
  miner_reg_pkg::reg_data_t                  rdata;
  miner_reg_pkg::axi_resp_t                  rresp;
  logic                                      rready;
  logic [`MINER_LANES-1:0]                   nonce_found;
  miner_work_pkg::nonce_t [`MINER_LANES-1:0] nonce;
  miner_work_pkg::block_t                    block;
  logic                                      new_block;

  // Register model
  miner_work_pkg::block_t model_block = '0;
  miner_work_pkg::nonce_t model_result = '0;
  miner_work_pkg::count_t model_cnt = '0;
  miner_work_pkg::tick_t  model_tick_cnt = '0;
  miner_work_pkg::tick_t  model_tick_value = '0;
  miner_work_pkg::count_t model_wmark = '0;
  miner_work_pkg::count_t model_load = '0;

  int          expected_pulses = 0;
  int          pulse_count = 0;
  int          cycle_count = 0;
  logic [31:0] lfsr_state = 32'h9923;

  miner_ctrl i_miner_ctrl (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .awvalid         (awvalid),
    .awaddr          (awaddr),
    .awready         (awready),
    .wvalid          (wvalid),
    .wdata           (wdata),
    .wstrb           (wstrb),
    .wready          (wready),
    .bvalid          (bvalid),
    .bresp           (bresp),
    .bready          (bready),
    .arvalid         (arvalid),
    .araddr          (araddr),
    .arready         (arready),
    .rvalid          (rvalid),
    .rdata           (rdata),
    .rresp           (rresp),
    .rready          (rready),
    .nonce_found     (nonce_found),
    .nonce           (nonce),
    .block           (block),
    .new_block       (new_block)
  );

  always #10 clk_main_a0 = ~clk_main_a0;

  always @(posedge clk_main_a0) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d clock cycles", TIMEOUT_CYCLES);
      abort_run();
    end
  end

  // Every new-block pulse is counted, wanted or not
  always @(negedge clk_main_a0) begin
    if (rst_main_n_sync && new_block) begin
      pulse_count <= pulse_count + 1;
    end
  end

  // --------------------------------------------------------------------------
  // Random source and reference model
  // --------------------------------------------------------------------------
  // Galois LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_state = {1'b0, lfsr_state[31:1]} ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
      bits = {bits[30:0], lfsr_state[0]};
    end
    return bits;
  endfunction

  function automatic miner_reg_pkg::reg_data_t expected_read(
    input miner_reg_pkg::reg_addr_t addr
  );
    miner_reg_pkg::reg_data_t exp;
    exp = `UNMAPPED_DATA;
    if (addr == `REG_RESULT) begin
      exp = model_result;
    end else if (addr == `REG_CNT_STATUS) begin
      exp        = '0;
      exp[15:0]  = model_cnt;
      exp[23:16] = model_tick_cnt;
      exp[24]    = model_cnt >= model_wmark;
      exp[25]    = model_tick_cnt >= model_tick_value;
    end
    return exp;
  endfunction

  // --------------------------------------------------------------------------
  // Compare tasks
  // --------------------------------------------------------------------------
  task automatic abort_run();
    $display("Simulation failed");
    $fatal(1, "run stopped at %0t", $time);
  endtask

  task automatic compare_data(input string name, input miner_reg_pkg::reg_data_t exp,
                              input miner_reg_pkg::reg_data_t act);
    if (act !== exp) begin
      $display("error %s: expected %h actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic compare_block(input string name, input miner_work_pkg::block_t exp,
                               input miner_work_pkg::block_t act);
    if (act !== exp) begin
      $display("error %s: expected %h actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic compare_nonce(input string name, input miner_work_pkg::nonce_t exp,
                               input miner_work_pkg::nonce_t act);
    if (act !== exp) begin
      $display("error %s: expected %h actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic compare_count(input string name, input miner_work_pkg::count_t exp,
                               input miner_work_pkg::count_t act);
    if (act !== exp) begin
      $display("error %s: expected %h actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic compare_resp(input string name, input miner_reg_pkg::axi_resp_t exp,
                              input miner_reg_pkg::axi_resp_t act);
    if (act !== exp) begin
      $display("error %s: expected %0d actual %0d", name, exp, act);
      abort_run();
    end
  endtask

  task automatic compare_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("error %s: expected %b actual %b", name, exp, act);
      abort_run();
    end
  endtask

  // --------------------------------------------------------------------------
  // Bus tasks, stall counts hold bready or rready low
  // --------------------------------------------------------------------------
  task automatic write_reg(input miner_reg_pkg::reg_addr_t addr,
                           input miner_reg_pkg::reg_data_t data, input int stall);
    @(negedge clk_main_a0);
    awvalid = 1'b1;
    awaddr  = addr;
    while (!awready) @(negedge clk_main_a0);
    @(negedge clk_main_a0);
    awvalid = 1'b0;
    wvalid  = 1'b1;
    wdata   = data;
    wstrb   = 4'hF;
    // wready follows wvalid combinationally
    #1;
    compare_bit("wready", 1'b1, wready);
    @(negedge clk_main_a0);
    wvalid = 1'b0;
    compare_bit("new_block_pulse", addr == `REG_BLOCK_LAST, new_block);
    if (addr == `REG_BLOCK_LAST) begin
      expected_pulses++;
    end
    repeat (stall) begin
      compare_bit("bvalid_hold", 1'b1, bvalid);
      compare_bit("awready_during_b", 1'b0, awready);
      @(negedge clk_main_a0);
    end
    compare_bit("bvalid", 1'b1, bvalid);
    compare_resp("bresp", miner_reg_pkg::RESP_OKAY, bresp);
    bready = 1'b1;
    @(negedge clk_main_a0);
    bready = 1'b0;
  endtask

  task automatic read_reg(input miner_reg_pkg::reg_addr_t addr, input int stall,
                          output miner_reg_pkg::reg_data_t data);
    miner_reg_pkg::reg_data_t held;
    @(negedge clk_main_a0);
    arvalid = 1'b1;
    araddr  = addr;
    while (!arready) @(negedge clk_main_a0);
    @(negedge clk_main_a0);
    arvalid = 1'b0;
    while (!rvalid) @(negedge clk_main_a0);
    held = rdata;
    repeat (stall) begin
      @(negedge clk_main_a0);
      compare_bit("rvalid_hold", 1'b1, rvalid);
      compare_data("rdata_hold", held, rdata);
      compare_bit("arready_during_r", 1'b0, arready);
    end
    compare_resp("rresp", miner_reg_pkg::RESP_OKAY, rresp);
    rready = 1'b1;
    data   = held;
    @(negedge clk_main_a0);
    rready = 1'b0;
  endtask

  task automatic check_read(input string name, input miner_reg_pkg::reg_addr_t addr);
    miner_reg_pkg::reg_data_t got;
    read_reg(addr, int'(rand_bits(2)), got);
    compare_data(name, expected_read(addr), got);
  endtask

  // --------------------------------------------------------------------------
  // Tests
  // --------------------------------------------------------------------------
  task automatic test_block_words();
    int                       order [`BLOCK_WORDS];
    int                       j;
    int                       tmp;
    miner_reg_pkg::reg_data_t word;
    for (int round = 0; round < 2; round++) begin
      for (int i = 0; i < `BLOCK_WORDS; i++) begin
        order[i] = i;
      end
      // Shuffle the word order
      for (int i = `BLOCK_WORDS - 1; i > 0; i--) begin
        j        = int'(rand_bits(5)) % (i + 1);
        tmp      = order[i];
        order[i] = order[j];
        order[j] = tmp;
      end
      for (int i = 0; i < `BLOCK_WORDS; i++) begin
        word = rand_bits(32);
        model_block[(`BLOCK_WORDS-1-order[i])*`WORD_WIDTH +: `WORD_WIDTH] = word;
        write_reg(miner_reg_pkg::reg_addr_t'(`REG_BLOCK_BASE + 4 * order[i]), word,
                  int'(rand_bits(2)));
      end
      compare_block("block_words", model_block, block);
    end
  endtask

  task automatic test_nonce_capture();
    logic [31:0]              bits;
    logic [`MINER_LANES-1:0]  pattern;
    logic                     hit;
    miner_reg_pkg::reg_data_t got;
    for (int n = 0; n < 40; n++) begin
      bits    = rand_bits(`MINER_LANES);
      pattern = bits[`MINER_LANES-1:0];
      @(negedge clk_main_a0);
      nonce_found = pattern;
      hit         = 1'b0;
      for (int i = 0; i < `MINER_LANES; i++) begin
        nonce[i] = rand_bits(32);
        if (pattern[i] && !hit) begin
          model_result = nonce[i];
          hit          = 1'b1;
        end
      end
      @(negedge clk_main_a0);
      nonce_found = '0;
      // New nonces without a strobe must leave the result alone
      for (int i = 0; i < `MINER_LANES; i++) begin
        nonce[i] = rand_bits(32);
      end
      read_reg(`REG_RESULT, int'(rand_bits(2)), got);
      compare_data("nonce_result_word", expected_read(`REG_RESULT), got);
      compare_nonce("nonce_result", model_result, got);
    end
  endtask

  task automatic test_unmapped();
    miner_reg_pkg::reg_addr_t fixed_addr [8] = '{
      32'h0000_0000, 32'h0000_0500, `REG_BLOCK_BASE, `REG_BLOCK_LAST,
      32'h0000_0558, `REG_CNT_CTRL, `REG_CNT_WMARK, 32'h0000_0574
    };
    for (int i = 0; i < 8; i++) begin
      check_read("unmapped_read", fixed_addr[i]);
    end
    for (int i = 0; i < 8; i++) begin
      check_read("random_read", rand_bits(32) & 32'hFFFF_FFFC);
    end
  endtask

  task automatic write_counter(input miner_reg_pkg::reg_addr_t addr,
                               input miner_reg_pkg::reg_data_t data);
    write_reg(addr, data, int'(rand_bits(2)));
  endtask

  task automatic check_status(input string name);
    miner_reg_pkg::reg_data_t got;
    read_reg(`REG_CNT_STATUS, int'(rand_bits(2)), got);
    compare_data(name, expected_read(`REG_CNT_STATUS), got);
    compare_count(name, model_cnt, got[15:0]);
  endtask

  task automatic test_counter_load_clear();
    for (int n = 0; n < 6; n++) begin
      model_tick_value = rand_bits(8);
      model_wmark      = rand_bits(16);
      model_load       = rand_bits(16);
      write_counter(`REG_CNT_TICK, model_tick_value);
      write_counter(`REG_CNT_WMARK, model_wmark);
      write_counter(`REG_CNT_LOAD, model_load);
      write_counter(`REG_CNT_CTRL, 32'h2);
      model_cnt = model_load;
      check_status("counter_load");
      write_counter(`REG_CNT_CTRL, 32'h4);
      model_cnt      = '0;
      model_tick_cnt = '0;
      check_status("counter_clear");
      write_counter(`REG_CNT_CTRL, 32'h0);
    end
  endtask

  task automatic test_oneshot();
    model_tick_value = '0;
    write_counter(`REG_CNT_TICK, 32'h0);
    write_counter(`REG_CNT_LOAD, 32'hFFFE);
    // Load held with one-shot set
    write_counter(`REG_CNT_CTRL, 32'hA);
    model_cnt = 16'hFFFE;
    check_status("oneshot_load");
    write_counter(`REG_CNT_CTRL, 32'h9);
    repeat (16) @(negedge clk_main_a0);
    model_cnt = 16'hFFFF;
    check_status("oneshot_saturate");
    repeat (16) @(negedge clk_main_a0);
    check_status("oneshot_hold");
    write_counter(`REG_CNT_CTRL, 32'h4);
    write_counter(`REG_CNT_CTRL, 32'h0);
    model_cnt = '0;
    check_status("oneshot_clear");
  endtask

  initial begin
    rst_main_n_sync = 1'b0;
    awvalid         = 1'b0;
    awaddr          = '0;
    wvalid          = 1'b0;
    wdata           = '0;
    wstrb           = '0;
    bready          = 1'b0;
    arvalid         = 1'b0;
    araddr          = '0;
    rready          = 1'b0;
    nonce_found     = '0;
    nonce           = '0;
    repeat (8) @(negedge clk_main_a0);
    rst_main_n_sync = 1'b1;
    @(negedge clk_main_a0);
    test_block_words();
    test_nonce_capture();
    test_unmapped();
    test_counter_load_clear();
    test_oneshot();
    compare_data("new_block_count", expected_pulses, pulse_count);
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

// ==== miner_ctrl.f ====
+incdir+hw
hw/miner_reg_pkg.sv
hw/miner_work_pkg.sv
hw/ocl_axil_slave.sv
hw/miner_csr.sv
hw/nonce_result_sel.sv
hw/tick_counter.sv
hw/miner_ctrl.sv
tb/miner_ctrl_tb.sv

// ==== Makefile ====
# Verilator build and run of the miner controller testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module miner_ctrl_tb \
	  -f miner_ctrl.f -Mdir obj_dir

# The log decides the result, the exit status of the binary backs it up
run: compile
	./obj_dir/Vminer_ctrl_tb > sim.log 2>&1; status=$$?; cat sim.log; \
	  if grep -q "Simulation failed" sim.log; then exit 1; fi; exit $$status

clean:
	rm -rf obj_dir sim.log
